// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  // **********************************************************************
  // Datapath and register file sizes
  // **********************************************************************
  localparam int dataWidth    = 32; // Register and result width
  localparam int regAddrWidth = 6;  // Register index width
  localparam int regCount     = 64; // Words per bank
  localparam int readPorts    = 2;  // Two or more read-port banks

  // **********************************************************************
  // Opcodes and instruction fields
  // **********************************************************************
  localparam logic [5:0] opAdd     = 6'd1;
  localparam logic [5:0] opSub     = 6'd2;
  localparam logic [5:0] opAnd     = 6'd3;
  localparam logic [5:0] opOr      = 6'd4;
  localparam logic [5:0] opLoadImm = 6'd5; // Writes the 14 bit immediate
  localparam logic [5:0] opMove    = 6'd6; // Copies source one

  localparam int opcodeHi = 31;
  localparam int opcodeLo = 26;

  localparam int srcOneHi = 25; // Source one feeds ALU operand A
  localparam int srcOneLo = 20;
  localparam int srcTwoHi = 19; // Source two or I-type destination
  localparam int srcTwoLo = 14;
  localparam int destHi   = 13; // R-type destination
  localparam int destLo   = 8;
  localparam int immHi    = 13; // Immediate overlaps the destination field
  localparam int immLo    = 0;

  localparam logic [dataWidth-1:0] haltWord = '1; // Stops the core until reset

  // Phase count at which the instruction word is taken
  localparam logic [1:0] samplePhase = 2'd2;

  // **********************************************************************
  // ALU operation select
  // **********************************************************************
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluImm,  // Zero extended immediate
    aluMove  // Operand A passes through
  } aluOp;

endpackage

`default_nettype wire

// ==== source/regBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module regBank
  import cpuPkg::*;
(
  input  wire logic                    CLOCK,
  input  wire logic                    rst,
  input  wire logic                    writeStrobe,
  input  wire logic [regAddrWidth-1:0] writeAddr,
  input  wire logic [dataWidth-1:0]    writeData,
  input  wire logic [regAddrWidth-1:0] readAddr,
  output logic      [dataWidth-1:0]    readData
);

  logic [dataWidth-1:0] regs [regCount]; // One copy of the register state

  // **********************************************************************
  // Write port, one word per cycle
  // **********************************************************************
  always_ff @(posedge CLOCK) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0; // All registers start at zero
      end
    end else if (writeStrobe) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Read is asynchronous so the ALU sees the value in the same cycle
  assign readData = regs[readAddr];

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile
  import cpuPkg::*;
(
  input  wire logic                                    CLOCK,
  input  wire logic                                    rst,
  input  wire logic                                    writeStrobe,
  input  wire logic [regAddrWidth-1:0]                 writeAddr,
  input  wire logic [dataWidth-1:0]                    writeData,
  input  wire logic [readPorts-1:0][regAddrWidth-1:0]  readAddr,
  output logic      [readPorts-1:0][dataWidth-1:0]     readData
);

  // **********************************************************************
  // One bank per read port
  // **********************************************************************
  // Every bank takes the same write, so the copies never drift apart
  // and any port may be read for any register.
  for (genvar port = 0; port < readPorts; port++) begin : gBank
    regBank u_regBank (
      .CLOCK       (CLOCK),
      .rst         (rst),
      .writeStrobe (writeStrobe),       // Shared write strobe
      .writeAddr   (writeAddr),
      .writeData   (writeData),
      .readAddr    (readAddr[port]),    // Private read address
      .readData    (readData[port])
    );
  end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit
  import cpuPkg::*;
(
  input  wire aluOp                    op,
  input  wire logic [dataWidth-1:0]   operandA,  // Source one
  input  wire logic [dataWidth-1:0]   operandB,  // Source two
  input  wire logic [immHi-immLo:0]   immediate,
  output logic      [dataWidth-1:0]   aluResult
);

  localparam int immWidth = immHi - immLo + 1;

  logic [dataWidth-1:0] immExtended;

  assign immExtended = {{(dataWidth - immWidth){1'b0}}, immediate}; // Zero extend

  // **********************************************************************
  // Result select
  // **********************************************************************
  always_comb begin
    case (op)
      aluAdd: begin
        aluResult = operandA + operandB; // Wraps modulo 2^32
      end
      aluSub: begin
        aluResult = operandA - operandB;
      end
      aluAnd: begin
        aluResult = operandA & operandB;
      end
      aluOr: begin
        aluResult = operandA | operandB;
      end
      aluImm: begin
        aluResult = immExtended;
      end
      aluMove: begin
        aluResult = operandA; // Copy of source one
      end
      default: begin
        aluResult = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/decodeExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecute
  import cpuPkg::*;
(
  input  wire logic                                   CLOCK,
  input  wire logic                                   rst,
  input  wire logic                                   run,          // Core runs while high
  input  wire logic [dataWidth-1:0]                   instruction,
  output logic      [readPorts-1:0][regAddrWidth-1:0] readAddr,
  output aluOp                                        op,
  output logic      [immHi-immLo:0]                   immediate,
  input  wire logic [dataWidth-1:0]                   aluResult,
  output logic      [dataWidth-1:0]                   result,
  output logic      [regAddrWidth-1:0]                address,
  output logic                                        writeStrobe,  // One cycle per write
  output logic                                        halted
);

  logic [1:0]              phase;      // Counts 0, 1, 2 and wraps
  logic                    takeWord;   // Sample edge
  logic                    pending;    // Latched word waits for execute
  logic [dataWidth-1:0]    instrReg;
  logic [5:0]              opcode;
  logic [regAddrWidth-1:0] srcOne;
  logic [regAddrWidth-1:0] srcTwo;
  logic [regAddrWidth-1:0] destField;
  logic [regAddrWidth-1:0] destAddr;   // Where the result lands
  logic                    writes;     // Opcode produces a register write

  assign takeWord = run && !halted && (phase == samplePhase);

  // **********************************************************************
  // Instruction fields
  // **********************************************************************
  assign opcode    = instrReg[opcodeHi:opcodeLo];
  assign srcOne    = instrReg[srcOneHi:srcOneLo];
  assign srcTwo    = instrReg[srcTwoHi:srcTwoLo];
  assign destField = instrReg[destHi:destLo];
  assign immediate = instrReg[immHi:immLo];

  always_comb begin
    for (int port = 0; port < readPorts; port++) begin
      readAddr[port] = destAddr; // Spare ports follow the destination
    end
    readAddr[0] = srcOne;        // Operand A
    readAddr[1] = srcTwo;        // Operand B
  end

  // **********************************************************************
  // Decode
  // **********************************************************************
  // R-type results go to the destination field. LOADI and MOVE write
  // the register named in the source two field instead.
  always_comb begin
    op       = aluAdd;
    destAddr = destField;
    writes   = 1'b0;
    case (opcode)
      opAdd: begin
        op     = aluAdd;
        writes = 1'b1;
      end
      opSub: begin
        op     = aluSub;
        writes = 1'b1;
      end
      opAnd: begin
        op     = aluAnd;
        writes = 1'b1;
      end
      opOr: begin
        op     = aluOr;
        writes = 1'b1;
      end
      opLoadImm: begin
        op       = aluImm;
        destAddr = srcTwo;
        writes   = 1'b1;
      end
      opMove: begin
        op       = aluMove;
        destAddr = srcTwo;
        writes   = 1'b1;
      end
      default: begin
        writes = 1'b0; // No-op, halt word and unknown opcodes
      end
    endcase
  end

  // **********************************************************************
  // Control state
  // **********************************************************************
  always_ff @(posedge CLOCK) begin
    if (rst) begin
      phase       <= '0;
      pending     <= 1'b0;
      writeStrobe <= 1'b0;
      halted      <= 1'b0;
    end else begin
      pending     <= takeWord;
      writeStrobe <= 1'b0;
      if (run && !halted) begin   // Run low freezes the count
        if (phase == samplePhase) begin
          phase <= '0;
        end else begin
          phase <= phase + 2'd1;
        end
      end
      if (pending) begin          // Execute edge
        if (instrReg == haltWord) begin
          halted <= 1'b1;         // Held until reset
        end else if (writes) begin
          writeStrobe <= 1'b1;
        end
      end
    end
  end

  // Instruction latch and write-back payload
  always_ff @(posedge CLOCK) begin
    if (takeWord) begin
      instrReg <= instruction;
    end
    if (pending) begin
      result  <= aluResult;
      address <= destAddr;
    end
  end

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore
  import cpuPkg::*;
(
  input  wire logic                    CLOCK,
  input  wire logic                    rst,
  input  wire logic                    run,
  input  wire logic [dataWidth-1:0]    instruction,
  output logic      [dataWidth-1:0]    result,
  output logic      [regAddrWidth-1:0] address,
  output logic                         writeStrobe,
  output logic                         halted
);

  logic [readPorts-1:0][regAddrWidth-1:0] readAddr;
  logic [readPorts-1:0][dataWidth-1:0]    readData;
  aluOp                                   op;
  logic [immHi-immLo:0]                   immediate;
  logic [dataWidth-1:0]                   aluResult;

  // **********************************************************************
  // Sequencing, decode and write-back
  // **********************************************************************
  decodeExecute u_decodeExecute (
    .CLOCK       (CLOCK),
    .rst         (rst),
    .run         (run),
    .instruction (instruction),
    .readAddr    (readAddr),
    .op          (op),
    .immediate   (immediate),
    .aluResult   (aluResult),
    .result      (result),
    .address     (address),
    .writeStrobe (writeStrobe),
    .halted      (halted)
  );

  registerFile u_registerFile (
    .CLOCK       (CLOCK),
    .rst         (rst),
    .writeStrobe (writeStrobe), // Write-back also leaves on the top ports
    .writeAddr   (address),
    .writeData   (result),
    .readAddr    (readAddr),
    .readData    (readData)
  );

  aluUnit u_aluUnit (
    .op          (op),
    .operandA    (readData[0]),
    .operandB    (readData[1]),
    .immediate   (immediate),
    .aluResult   (aluResult)
  );

endmodule

`default_nettype wire

// ==== bench/cpuCore_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore_chk (
  input wire logic CLOCK,
  input wire logic rst,
  input wire logic writeStrobe,
  input wire logic halted
);

  int failCount = 0;  // Failed assertion count

  // **********************************************************************
  // Write strobe and halt rules
  // **********************************************************************
  strobeOneCycle: assert property (
    @(posedge CLOCK) disable iff (rst) writeStrobe |=> !writeStrobe
  ) else begin
    $error("writeStrobe stayed high for two cycles");
    failCount++;
  end

  haltHolds: assert property (
    @(posedge CLOCK) (halted && !rst) |=> halted  // Only reset clears it
  ) else begin
    $error("halted dropped without a reset");
    failCount++;
  end

  noWriteWhenHalted: assert property (
    @(posedge CLOCK) (halted && !rst) |=> !writeStrobe
  ) else begin
    $error("writeStrobe rose while the core was halted");
    failCount++;
  end

endmodule

bind decodeExecute cpuCore_chk u_cpuCoreChk (
  .CLOCK       (CLOCK),
  .rst         (rst),
  .writeStrobe (writeStrobe),
  .halted      (halted)
);

`default_nettype wire

// ==== bench/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb
  import cpuPkg::*;
();

  typedef struct packed {
    logic [dataWidth-1:0]    word;
    logic                    expectWrite;
    logic [regAddrWidth-1:0] expectAddr;
    logic [dataWidth-1:0]    expectValue;
  } tableRow;

  logic                    CLOCK = 1'b0;
  logic                    rst;
  logic                    run;
  logic [dataWidth-1:0]    instruction;
  logic [dataWidth-1:0]    result;
  logic [regAddrWidth-1:0] address;
  logic                    writeStrobe;
  logic                    halted;

  tableRow rows [$];
  int      haltSegmentEnd;    // Last row before the second reset
  int      valueErrors  = 0;
  int      strobeErrors = 0;
  bit      tableReady   = 1'b0;

  always #4 CLOCK = ~CLOCK;   // 8 ns period

  cpuCore u_cpuCore (
    .CLOCK       (CLOCK),
    .rst         (rst),
    .run         (run),
    .instruction (instruction),
    .result      (result),
    .address     (address),
    .writeStrobe (writeStrobe),
    .halted      (halted)
  );

  // **********************************************************************
  // Instruction encoding and the stimulus table
  // **********************************************************************
  function automatic logic [dataWidth-1:0] regWord(input logic [5:0] opcode,
      input logic [5:0] srcA, input logic [5:0] srcB, input logic [5:0] dest);
    logic [dataWidth-1:0] word;
    word = '0;
    word[opcodeHi:opcodeLo] = opcode;
    word[srcOneHi:srcOneLo] = srcA;
    word[srcTwoHi:srcTwoLo] = srcB;   // Also the MOVE target
    word[destHi:destLo]     = dest;
    return word;
  endfunction

  function automatic logic [dataWidth-1:0] immWord(input logic [5:0] opcode,
      input logic [5:0] target, input logic [13:0] imm);
    logic [dataWidth-1:0] word;
    word = '0;
    word[opcodeHi:opcodeLo] = opcode;
    word[srcTwoHi:srcTwoLo] = target;
    word[immHi:immLo]       = imm;
    return word;
  endfunction

  task automatic addRow(input logic [dataWidth-1:0] word, input logic expectWrite,
      input logic [regAddrWidth-1:0] expectAddr, input logic [dataWidth-1:0] expectValue);
    tableRow row;
    row.word        = word;
    row.expectWrite = expectWrite;
    row.expectAddr  = expectAddr;
    row.expectValue = expectValue;
    rows.push_back(row);
  endtask

  task automatic buildTable();
    addRow(immWord(opLoadImm, 6'd1, 14'h1234), 1'b1, 6'd1, 32'h0000_1234);
    addRow(immWord(opLoadImm, 6'd2, 14'h3fff), 1'b1, 6'd2, 32'h0000_3fff);
    addRow(immWord(opLoadImm, 6'd3, 14'h0005), 1'b1, 6'd3, 32'h0000_0005);
    addRow(regWord(opAdd, 6'd1, 6'd2, 6'd4), 1'b1, 6'd4, 32'h0000_5233);
    addRow(regWord(opSub, 6'd3, 6'd2, 6'd5), 1'b1, 6'd5, 32'hffff_c006); // Wraps below zero
    addRow(regWord(opSub, 6'd2, 6'd1, 6'd6), 1'b1, 6'd6, 32'h0000_2dcb);
    addRow(immWord(opLoadImm, 6'd7, 14'h2aaa), 1'b1, 6'd7, 32'h0000_2aaa);
    addRow(immWord(opLoadImm, 6'd8, 14'h0ff0), 1'b1, 6'd8, 32'h0000_0ff0);
    addRow(regWord(opAnd, 6'd7, 6'd8, 6'd9), 1'b1, 6'd9, 32'h0000_0aa0);
    addRow(regWord(opOr, 6'd7, 6'd8, 6'd10), 1'b1, 6'd10, 32'h0000_2ffa);
    addRow(regWord(opOr, 6'd5, 6'd7, 6'd11), 1'b1, 6'd11, 32'hffff_eaae);
    addRow(regWord(opAnd, 6'd5, 6'd4, 6'd12), 1'b1, 6'd12, 32'h0000_4002);
    addRow(regWord(opMove, 6'd5, 6'd20, 6'd0), 1'b1, 6'd20, 32'hffff_c006);
    addRow(regWord(opAdd, 6'd20, 6'd1, 6'd21), 1'b1, 6'd21, 32'hffff_d23a); // Port 0 bank
    addRow(regWord(opAdd, 6'd1, 6'd20, 6'd22), 1'b1, 6'd22, 32'hffff_d23a); // Port 1 bank
    addRow(32'h0000_0000, 1'b0, 6'd0, 32'h0);                    // No-op
    addRow(regWord(6'd7, 6'd2, 6'd1, 6'd1), 1'b0, 6'd0, 32'h0);  // Would hit r1 if decoded
    addRow(regWord(opMove, 6'd1, 6'd23, 6'd0), 1'b1, 6'd23, 32'h0000_1234);
    addRow(haltWord, 1'b0, 6'd0, 32'h0);
    addRow(immWord(opLoadImm, 6'd30, 14'h0077), 1'b0, 6'd0, 32'h0);
    addRow(regWord(opAdd, 6'd1, 6'd2, 6'd31), 1'b0, 6'd0, 32'h0);
    haltSegmentEnd = rows.size() - 1;
    addRow(regWord(opAdd, 6'd1, 6'd2, 6'd24), 1'b1, 6'd24, 32'h0);  // Registers back at zero
    addRow(regWord(opMove, 6'd4, 6'd25, 6'd0), 1'b1, 6'd25, 32'h0);
  endtask

  // **********************************************************************
  // Checking
  // **********************************************************************
  task automatic checkValue(input string name, input logic [dataWidth-1:0] got,
      input logic [dataWidth-1:0] expected);
    if (got !== expected) begin
      valueErrors++;
      $display("error at time %0t: %s got 0x%h, expected 0x%h", $time, name, got, expected);
    end
  endtask

  task automatic judgeRow(input int idx, input int strobes,
      input logic [regAddrWidth-1:0] gotAddr, input logic [dataWidth-1:0] gotValue);
    if (strobes > 1) begin
      strobeErrors++;
      $display("row %0d produced %0d write strobes instead of one", idx, strobes);
    end
    if (rows[idx].expectWrite) begin
      if (strobes == 0) begin
        strobeErrors++;
        $display("row %0d should have written a register, but writeStrobe never pulsed", idx);
      end else begin
        checkValue("address", 32'(gotAddr), 32'(rows[idx].expectAddr));
        checkValue("result", gotValue, rows[idx].expectValue);
      end
    end else if (strobes != 0) begin
      strobeErrors++;
      $display("row %0d wrote register %0d although it should write nothing", idx, gotAddr);
    end
  endtask

  // One row per three-cycle window; window k sees the strobe of row k-1
  task automatic runRows(input int first, input int last);
    int                      strobes;
    logic [regAddrWidth-1:0] gotAddr;
    logic [dataWidth-1:0]    gotValue;
    @(posedge CLOCK);
    run <= 1'b1;
    for (int k = first; k <= last + 1; k++) begin
      if (k <= last) begin
        instruction <= rows[k].word;
      end else begin
        instruction <= '0;          // Trailing window drains the last row
      end
      strobes  = 0;
      gotAddr  = '0;
      gotValue = '0;
      repeat (3) begin
        @(negedge CLOCK);           // Outputs settled
        if (writeStrobe) begin
          strobes++;
          gotAddr  = address;
          gotValue = result;
        end
        @(posedge CLOCK);
      end
      if (k > first) begin
        judgeRow(k - 1, strobes, gotAddr, gotValue);
      end
    end
    run <= 1'b0;
  endtask

  // **********************************************************************
  // Main sequence
  // **********************************************************************
  initial begin
    int assertFails;
    rst         = 1'b1;
    run         = 1'b0;
    instruction = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (3) @(posedge CLOCK);
    rst <= 1'b0;

    runRows(0, haltSegmentEnd);
    @(negedge CLOCK);
    checkValue("halted", 32'(halted), 32'd1);

    @(posedge CLOCK);
    rst <= 1'b1;                    // Clears halt and every bank
    repeat (3) @(posedge CLOCK);
    rst <= 1'b0;
    @(negedge CLOCK);
    checkValue("halted", 32'(halted), 32'd0);
    runRows(haltSegmentEnd + 1, rows.size() - 1);

    assertFails = u_cpuCore.u_decodeExecute.u_cpuCoreChk.failCount;
    $display("errors: %0d value mismatches, %0d strobe faults, %0d assertion failures",
             valueErrors, strobeErrors, assertFails);
    if (valueErrors + strobeErrors + assertFails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Limit from table length, two trailing windows and two resets
  initial begin
    int limitNs;
    wait (tableReady);
    limitNs = (rows.size() + 2) * 3 * 8 + 2 * 5 * 8 + 200;
    #(limitNs);
    $display("watchdog expired: the run did not finish within %0d ns", limitNs);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
source/cpuPkg.sv
source/regBank.sv
source/registerFile.sv
source/aluUnit.sv
source/decodeExecute.sv
source/cpuCore.sv
bench/cpuCore_chk.sv
bench/cpuCoreTb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the cpuCore project

VERILATOR ?= verilator
TOP       ?= cpuCoreTb
DUT_TOP   ?= cpuCore
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
